//--- project.f
verilog/cordic_pkg.sv
verilog/cordic_atan_rom.sv
verilog/cordic_datapath.sv
verilog/cordic_control.sv
verilog/cordic_result_stage.sv
verilog/cordic_coprocessor.sv
verification/tb_cordic.sv

//--- run.sh
#!/bin/sh
# Builds the CORDIC testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module tb_cordic -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "All checks passed" sim.log; then
	exit 0
fi
exit 1

//--- verification/tb_cordic.sv
`timescale 1ns/100ps

module tb_cordic;

	localparam int ITERATIONS = 24;
	localparam int NUM_CALCS = 34; // Calculations started over all six tests.
	localparam int TIMEOUT_CYCLES = NUM_CALCS * ITERATIONS * 3 * 14 + 500;
	localparam logic [31:0] X_START = 32'h3f1b74ee; // 1/K in single precision.

	logic        clk, reset, beg_fsm_cordic, ack_cordic, operation, ready_add_subt;
	logic [31:0] data_in, result_add_subt;
	logic [1:0]  shift_region_flag;
	logic        ready_cordic, beg_add_subt, ack_add_subt, op_add_subt;
	logic [31:0] add_subt_dataA, add_subt_dataB, data_output;

	logic [31:0] atan_tab [0:31] = '{
		32'h3f490fdb, 32'h3eed6338, 32'h3e7adbb0, 32'h3dfeadd5,
		32'h3d7faade, 32'h3cffeaae, 32'h3c7ffaab, 32'h3bfffeab,
		32'h3b7fffab, 32'h3affffeb, 32'h3a7ffffb, 32'h39ffffff,
		32'h39800000, 32'h39000000, 32'h38800000, 32'h38000000,
		32'h37800000, 32'h37000000, 32'h36800000, 32'h36000000,
		32'h35800000, 32'h35000000, 32'h34800000, 32'h34000000,
		32'h33800000, 32'h33000000, 32'h32800000, 32'h32000000,
		32'h31800000, 32'h31000000, 32'h30800000, 32'h30000000
	};

	logic [31:0] lfsr_state = 32'he1eb_152e;
	logic [31:0] exp_a[$];      // Expected adder requests, oldest first.
	logic [31:0] exp_b[$];
	logic        exp_op[$];
	logic [31:0] exp_result;    // Reference data_output of the running calculation.
	logic [31:0] got_result;    // Last data_output seen when ready_cordic rose.
	logic [31:0] pending_sum;   // What the adder model will answer.
	logic [31:0] add_rnd;
	logic [2:0]  add_wait;
	logic        add_busy, ready_prev;
	int          result_count, req_count, errors, req_errors, tests_run, tests_failed;
	int          cycle_count;

	cordic_coprocessor #(
		.ITERATIONS(ITERATIONS)
	) dut0 (
		.clk(clk), .reset(reset),
		.beg_fsm_cordic(beg_fsm_cordic), .ack_cordic(ack_cordic), .operation(operation),
		.ready_add_subt(ready_add_subt), .data_in(data_in), .result_add_subt(result_add_subt),
		.shift_region_flag(shift_region_flag), .ready_cordic(ready_cordic),
		.beg_add_subt(beg_add_subt), .ack_add_subt(ack_add_subt), .op_add_subt(op_add_subt),
		.add_subt_dataA(add_subt_dataA), .add_subt_dataB(add_subt_dataB),
		.data_output(data_output)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period.
	end

	//////////////////////////////////////////////////
	// Models.
	//////////////////////////////////////////////////

	// Galois LFSR, one step per bit handed out.
	function automatic logic [31:0] lfsr_take(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int k = 0; k < n; k++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	// Float add with truncation. Zero exponents count as zero.
	function automatic logic [31:0] float_add(input logic [31:0] a, input logic [31:0] b,
		input logic sub);
		logic        sa, sb, st;
		logic [7:0]  ea, eb, et, diff;
		logic [26:0] ma, mb, mt;
		logic [27:0] sum;
		logic [8:0]  er;
		sa = a[31];
		sb = b[31] ^ sub; // Subtracting is adding the negated operand.
		if (a[30:23] == 8'd0)
			return {sb, b[30:0]};
		if (b[30:23] == 8'd0)
			return a;
		ea = a[30:23];
		eb = b[30:23];
		ma = {1'b1, a[22:0], 3'b000}; // Hidden bit plus three guard bits.
		mb = {1'b1, b[22:0], 3'b000};
		if ({eb, mb} > {ea, ma})
		begin
			st = sa;
			sa = sb;
			sb = st;
			et = ea;
			ea = eb;
			eb = et;
			mt = ma;
			ma = mb;
			mb = mt;
		end
		diff = ea - eb;
		mb = (diff > 8'd26) ? 27'd0 : (mb >> diff); // Align, dropping shifted-out bits.
		sum = (sa == sb) ? ({1'b0, ma} + {1'b0, mb}) : ({1'b0, ma} - {1'b0, mb});
		if (sum == 28'd0)
			return 32'd0;
		er = {1'b0, ea};
		if (sum[27])
		begin
			sum = sum >> 1; // Carry out of the top.
			er = er + 9'd1;
		end
		while (!sum[26])
		begin
			sum = sum << 1;
			er = er - 9'd1;
		end
		if (er == 9'd0 || er[8])
			return {sa, 31'd0}; // Underflow flushes to zero.
		return {sa, er[7:0], sum[25:3]};
	endfunction

	// Multiply by 2^-n through the exponent; zero stays zero.
	function automatic logic [31:0] scale_pow2(input logic [31:0] value, input logic [7:0] n);
		if (value[30:23] == 8'd0)
			return value;
		return {value[31], value[30:23] - n, value[22:0]};
	endfunction

	function automatic logic region_negates(input logic sine, input logic [1:0] region);
		if (sine)
			return (region == 2'd2) || (region == 2'd3);
		return (region == 2'd1) || (region == 2'd2);
	endfunction

	// Replays the rotation and queues each add request it implies.
	function automatic logic [31:0] ref_cordic(input logic [31:0] angle, input logic sine,
		input logic [1:0] region);
		logic [31:0] x, y, z, xn, yn, zn, r;
		logic        s;
		x = X_START;
		y = 32'd0;
		z = angle;
		for (int i = 0; i < ITERATIONS; i++)
		begin
			s = z[31]; // Rotate toward zero angle.
			xn = float_add(x, scale_pow2(y, 8'(i)), !s);
			yn = float_add(y, scale_pow2(x, 8'(i)), s);
			zn = float_add(z, atan_tab[i], !s);
			exp_a.push_back(x);
			exp_b.push_back(scale_pow2(y, 8'(i)));
			exp_op.push_back(!s);
			exp_a.push_back(y);
			exp_b.push_back(scale_pow2(x, 8'(i)));
			exp_op.push_back(s);
			exp_a.push_back(z);
			exp_b.push_back(atan_tab[i]);
			exp_op.push_back(!s);
			x = xn;
			y = yn;
			z = zn;
		end
		r = sine ? y : x;
		r[31] = r[31] ^ region_negates(sine, region);
		return r;
	endfunction

	function automatic logic [31:0] random_angle();
		logic [31:0] rnd;
		logic        sgn;
		logic [7:0]  ex;
		logic [22:0] mant;
		rnd = lfsr_take(1);
		sgn = rnd[0];
		rnd = lfsr_take(4);
		ex = 8'd111 + {4'd0, rnd[3:0]}; // 2^-16 up to 2^-1.
		rnd = lfsr_take(23);
		mant = rnd[22:0];
		if (ex == 8'd126)
			mant[22] = 1'b0; // Keeps the magnitude under 0.75.
		return {sgn, ex, mant};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
		errors++;
	endtask

	// Adder model. Checks each request, then answers after 0 to 7 cycles.
	always @(negedge clk)
	begin
		if (reset)
		begin
			ready_add_subt = 1'b0;
			add_busy = 1'b0;
		end
		else
		begin
			if (!add_busy && beg_add_subt)
			begin
				req_count++;
				if (exp_a.size() == 0)
				begin
					$display("unexpected add request at %0t", $time);
					errors++;
					req_errors++;
				end
				else
				begin
					if (add_subt_dataA !== exp_a[0] || add_subt_dataB !== exp_b[0]
						|| op_add_subt !== exp_op[0])
						req_errors++;
					if (add_subt_dataA !== exp_a[0])
						report_mismatch("add_subt_dataA", exp_a[0], add_subt_dataA);
					if (add_subt_dataB !== exp_b[0])
						report_mismatch("add_subt_dataB", exp_b[0], add_subt_dataB);
					if (op_add_subt !== exp_op[0])
						report_mismatch("op_add_subt", {31'd0, exp_op[0]},
							{31'd0, op_add_subt});
					void'(exp_a.pop_front());
					void'(exp_b.pop_front());
					void'(exp_op.pop_front());
				end
				pending_sum = float_add(add_subt_dataA, add_subt_dataB, op_add_subt);
				add_rnd = lfsr_take(3);
				add_wait = add_rnd[2:0];
				add_busy = 1'b1;
			end
			if (add_busy && !ready_add_subt)
			begin
				if (add_wait == 3'd0)
				begin
					ready_add_subt = 1'b1;
					result_add_subt = pending_sum;
				end
				else
					add_wait = add_wait - 3'd1;
			end
			else if (add_busy && ack_add_subt)
			begin
				ready_add_subt = 1'b0; // Result was taken.
				add_busy = 1'b0;
			end
		end
	end

	// Compares data_output with the reference when ready_cordic rises.
	always @(negedge clk)
	begin
		if (reset)
			ready_prev = 1'b0;
		else
		begin
			if (ready_cordic && !ready_prev)
			begin
				if (data_output !== exp_result)
					report_mismatch("data_output", exp_result, data_output);
				got_result = data_output;
				result_count++;
			end
			ready_prev = ready_cordic;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus.
	//////////////////////////////////////////////////

	task automatic start_calc(input logic [31:0] angle, input logic sine, input logic [1:0] region);
		exp_result = ref_cordic(angle, sine, region);
		req_count = 0;
		@(negedge clk);
		data_in = angle;
		operation = sine;
		shift_region_flag = region;
		beg_fsm_cordic = 1'b1; // One-cycle start strobe.
		@(negedge clk);
		beg_fsm_cordic = 1'b0;
	endtask

	task automatic wait_result();
		int seen;
		seen = result_count;
		while (result_count == seen)
			@(negedge clk);
	endtask

	task automatic give_ack();
		@(negedge clk);
		ack_cordic = 1'b1;
		@(negedge clk);
		ack_cordic = 1'b0;
	endtask

	task automatic run_calc(input logic [31:0] angle, input logic sine, input logic [1:0] region);
		start_calc(angle, sine, region);
		wait_result();
		give_ack();
		if (req_count != 3 * ITERATIONS)
		begin
			$display("calculation issued %0d add requests instead of %0d", req_count,
				3 * ITERATIONS);
			errors++;
		end
	endtask

	task automatic control_low(input string when);
		if (ready_cordic !== 1'b0 || beg_add_subt !== 1'b0 || ack_add_subt !== 1'b0)
		begin
			$display("control outputs not low %s at %0t", when, $time);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors)
			$display("test %s: pass", name);
		else
		begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", name, errors - start_errors);
		end
	endtask

	initial
	begin
		int          start_errors;
		logic [31:0] angle, base, held;
		logic [31:0] rnd;
		reset = 1'b1;
		beg_fsm_cordic = 1'b0;
		ack_cordic = 1'b0;
		operation = 1'b0;
		ready_add_subt = 1'b0;
		data_in = 32'd0;
		result_add_subt = 32'd0;
		shift_region_flag = 2'd0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		start_errors = errors;
		@(negedge clk);
		control_low("after reset");
		run_calc(32'd0, 1'b0, 2'd0); // Cosine of zero.
		run_calc(32'd0, 1'b1, 2'd0);
		report_test("1 reset and zero angle", start_errors);

		start_errors = errors;
		for (int n = 0; n < 20; n++)
		begin
			angle = random_angle();
			rnd = lfsr_take(1);
			run_calc(angle, rnd[0], 2'd0);
		end
		report_test("2 random angles", start_errors);

		// Requests were checked all along by the adder model.
		tests_run++;
		if (req_errors == 0)
			$display("test 3 add request sequence: pass");
		else
		begin
			tests_failed++;
			$display("test 3 add request sequence: FAIL with %0d bad requests", req_errors);
		end

		start_errors = errors;
		for (int s = 0; s < 2; s++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				run_calc(32'h3f060a92, s[0], r[1:0]); // About pi/6.
				if (r == 0)
					base = got_result;
				else
				begin
					if (got_result[30:0] !== base[30:0])
						report_mismatch("data_output magnitude", base, got_result);
					if (got_result[31] !== (base[31] ^ region_negates(s[0], r[1:0])))
						report_mismatch("data_output sign",
							{31'd0, base[31] ^ region_negates(s[0], r[1:0])},
							{31'd0, got_result[31]});
				end
			end
		end
		report_test("4 region signs", start_errors);

		start_errors = errors;
		start_calc(32'h3e8a3d71, 1'b1, 2'd0);
		wait_result();
		held = got_result;
		for (int c = 0; c < 30; c++)
		begin
			@(negedge clk);
			beg_fsm_cordic = (c == 10); // A start while holding must be ignored.
			data_in = (c == 10) ? 32'hbf000000 : data_in;
			if (ready_cordic !== 1'b1)
			begin
				$display("ready_cordic dropped without ack_cordic at %0t", $time);
				errors++;
			end
			if (data_output !== held)
				report_mismatch("data_output", held, data_output);
		end
		give_ack();
		repeat (10) @(negedge clk);
		control_low("after the held result was taken"); // No request from the ignored start.
		run_calc(32'hbeb33333, 1'b0, 2'd3);
		report_test("5 withheld ack", start_errors);

		start_errors = errors;
		start_calc(32'h3f2ccccd, 1'b1, 2'd1);
		while (req_count < 10)
			@(negedge clk);
		reset = 1'b1; // Abort in the middle of the rotations.
		repeat (3) @(negedge clk);
		control_low("during reset");
		exp_a.delete();
		exp_b.delete();
		exp_op.delete();
		reset = 1'b0;
		@(negedge clk);
		run_calc(32'h3f2ccccd, 1'b1, 2'd1);
		report_test("6 reset mid calculation", start_errors);

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Ends a run that stops making progress.
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- verilog/cordic_atan_rom.sv
`timescale 1ns/100ps

module cordic_atan_rom (
	input  logic [cordic_pkg::ITER_WIDTH-1:0] iter,
	output logic [cordic_pkg::WORD_WIDTH-1:0] atan_value
);

	// Each entry is atan(2^-i) in single precision.
	// Past i = 12 the angle equals 2^-i to float accuracy, so only the exponent moves.
	always_comb
	begin
		case (iter)
			5'd0:    atan_value = 32'h3f490fdb; // pi/4.
			5'd1:    atan_value = 32'h3eed6338;
			5'd2:    atan_value = 32'h3e7adbb0;
			5'd3:    atan_value = 32'h3dfeadd5;
			5'd4:    atan_value = 32'h3d7faade;
			5'd5:    atan_value = 32'h3cffeaae;
			5'd6:    atan_value = 32'h3c7ffaab;
			5'd7:    atan_value = 32'h3bfffeab;
			5'd8:    atan_value = 32'h3b7fffab;
			5'd9:    atan_value = 32'h3affffeb;
			5'd10:   atan_value = 32'h3a7ffffb;
			5'd11:   atan_value = 32'h39ffffff;
			5'd12:   atan_value = 32'h39800000; // From here on a plain power of two.
			5'd13:   atan_value = 32'h39000000;
			5'd14:   atan_value = 32'h38800000;
			5'd15:   atan_value = 32'h38000000;
			5'd16:   atan_value = 32'h37800000;
			5'd17:   atan_value = 32'h37000000;
			5'd18:   atan_value = 32'h36800000;
			5'd19:   atan_value = 32'h36000000;
			5'd20:   atan_value = 32'h35800000;
			5'd21:   atan_value = 32'h35000000;
			5'd22:   atan_value = 32'h34800000;
			5'd23:   atan_value = 32'h34000000;
			5'd24:   atan_value = 32'h33800000;
			5'd25:   atan_value = 32'h33000000;
			5'd26:   atan_value = 32'h32800000;
			5'd27:   atan_value = 32'h32000000;
			5'd28:   atan_value = 32'h31800000;
			5'd29:   atan_value = 32'h31000000;
			5'd30:   atan_value = 32'h30800000;
			5'd31:   atan_value = 32'h30000000;
			default: atan_value = '0; // Only reachable with a wider index.
		endcase
	end

endmodule

//--- verilog/cordic_control.sv
`timescale 1ns/100ps

module cordic_control #(
	parameter int ITERATIONS = 24
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              beg_fsm_cordic,
	input  logic                              ack_cordic,
	input  logic                              ready_add_subt,
	output logic                              ready_cordic,
	output logic                              beg_add_subt,
	output logic                              ack_add_subt,
	output logic                              load_inputs,
	output logic                              fetch_iter,
	output logic                              store_result,
	output logic                              out_load,
	output logic [cordic_pkg::ITER_WIDTH-1:0] iter,
	output cordic_pkg::cordic_var_t           var_sel
);

	cordic_pkg::cordic_state_t state, state_next;
	logic last_iter;

	assign last_iter = (iter == cordic_pkg::ITER_WIDTH'(ITERATIONS - 1));

	//////////////////////////////////////////////////
	// State register and next state.
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= cordic_pkg::idle;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			cordic_pkg::idle:
				if (beg_fsm_cordic)
					state_next = cordic_pkg::load; // Start is ignored anywhere else.
			cordic_pkg::load:     state_next = cordic_pkg::fetch;
			cordic_pkg::fetch:    state_next = cordic_pkg::request;
			cordic_pkg::request:  state_next = cordic_pkg::wait_sum;
			cordic_pkg::wait_sum:
				if (ready_add_subt)
					state_next = cordic_pkg::store;
			cordic_pkg::store:    state_next = cordic_pkg::next;
			cordic_pkg::next:
			begin
				if (var_sel != cordic_pkg::var_z)
					state_next = cordic_pkg::request; // Same iteration, next variable.
				else if (last_iter)
					state_next = cordic_pkg::finish;
				else
					state_next = cordic_pkg::fetch;   // Fresh X, Y, Z for the next step.
			end
			cordic_pkg::finish:   state_next = cordic_pkg::hold;
			cordic_pkg::hold:
				if (ack_cordic)
					state_next = cordic_pkg::idle;
			default:              state_next = cordic_pkg::idle;
		endcase
	end

	//////////////////////////////////////////////////
	// Iteration and variable counters.
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			iter    <= '0;
			var_sel <= cordic_pkg::var_x;
		end
		else if (state == cordic_pkg::load)
		begin
			iter    <= '0;
			var_sel <= cordic_pkg::var_x;
		end
		else if (state == cordic_pkg::next)
		begin
			if (var_sel != cordic_pkg::var_z)
				var_sel <= cordic_pkg::cordic_var_t'(var_sel + 2'd1);
			else if (!last_iter)
			begin
				var_sel <= cordic_pkg::var_x; // Order is always X, Y, Z.
				iter    <= iter + 1'b1;
			end
		end
	end

	// Datapath enables decode straight from the state.
	assign load_inputs  = (state == cordic_pkg::load);
	assign fetch_iter   = (state == cordic_pkg::fetch);
	assign store_result = (state == cordic_pkg::store);
	assign out_load     = (state == cordic_pkg::finish);

	// Handshake outputs come from flops so they are glitch free.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			beg_add_subt <= 1'b0;
			ack_add_subt <= 1'b0;
			ready_cordic <= 1'b0;
		end
		else
		begin
			beg_add_subt <= (state_next == cordic_pkg::request); // High while in request.
			ack_add_subt <= (state == cordic_pkg::store);        // Cycle after the latch.
			ready_cordic <= (state_next == cordic_pkg::hold);
		end
	end

	// The result must stay offered until the consumer takes it.
	ready_held: assert property (@(posedge clk) disable iff (reset)
		ready_cordic && !ack_cordic |=> ready_cordic)
		else $error("ready_cordic dropped before ack_cordic");

endmodule

//--- verilog/cordic_coprocessor.sv
`timescale 1ns/100ps

module cordic_coprocessor #(
	parameter int ITERATIONS = 24 // Rotations per result, 1 to 32.
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              beg_fsm_cordic,
	input  logic                              ack_cordic,
	input  logic                              operation,
	input  logic                              ready_add_subt,
	input  logic [cordic_pkg::WORD_WIDTH-1:0] data_in,
	input  logic [cordic_pkg::WORD_WIDTH-1:0] result_add_subt,
	input  logic [1:0]                        shift_region_flag,
	output logic                              ready_cordic,
	output logic                              beg_add_subt,
	output logic                              ack_add_subt,
	output logic                              op_add_subt,
	output logic [cordic_pkg::WORD_WIDTH-1:0] add_subt_dataA,
	output logic [cordic_pkg::WORD_WIDTH-1:0] add_subt_dataB,
	output logic [cordic_pkg::WORD_WIDTH-1:0] data_output
);

	logic                              load_inputs, fetch_iter, store_result, out_load;
	logic [cordic_pkg::ITER_WIDTH-1:0] iter;
	cordic_pkg::cordic_var_t           var_sel;
	logic [cordic_pkg::WORD_WIDTH-1:0] atan_value;
	logic [cordic_pkg::WORD_WIDTH-1:0] x_final, y_final;

	// Sequencer and adder handshake.
	cordic_control #(
		.ITERATIONS(ITERATIONS)
	) control0 (
		.clk(clk), .reset(reset),
		.beg_fsm_cordic(beg_fsm_cordic), .ack_cordic(ack_cordic),
		.ready_add_subt(ready_add_subt), .ready_cordic(ready_cordic),
		.beg_add_subt(beg_add_subt), .ack_add_subt(ack_add_subt),
		.load_inputs(load_inputs), .fetch_iter(fetch_iter),
		.store_result(store_result), .out_load(out_load),
		.iter(iter), .var_sel(var_sel)
	);

	// X, Y, Z registers and operand muxing.
	cordic_datapath datapath0 (
		.clk(clk), .reset(reset),
		.load_inputs(load_inputs), .fetch_iter(fetch_iter), .store_result(store_result),
		.data_in(data_in), .result_add_subt(result_add_subt), .atan_value(atan_value),
		.iter(iter), .var_sel(var_sel),
		.add_subt_dataA(add_subt_dataA), .add_subt_dataB(add_subt_dataB),
		.op_add_subt(op_add_subt), .x_final(x_final), .y_final(y_final)
	);

	cordic_atan_rom atan_rom0 (
		.iter(iter),
		.atan_value(atan_value)
	);

	// Picks sine or cosine and applies the quadrant sign.
	cordic_result_stage result0 (
		.clk(clk), .reset(reset),
		.load_inputs(load_inputs), .out_load(out_load), .operation(operation),
		.shift_region_flag(shift_region_flag),
		.x_final(x_final), .y_final(y_final),
		.data_output(data_output)
	);

endmodule

//--- verilog/cordic_datapath.sv
`timescale 1ns/100ps

module cordic_datapath (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                load_inputs,
	input  logic                                fetch_iter,
	input  logic                                store_result,
	input  logic [cordic_pkg::WORD_WIDTH-1:0]   data_in,
	input  logic [cordic_pkg::WORD_WIDTH-1:0]   result_add_subt,
	input  logic [cordic_pkg::WORD_WIDTH-1:0]   atan_value,
	input  logic [cordic_pkg::ITER_WIDTH-1:0]   iter,
	input  cordic_pkg::cordic_var_t             var_sel,
	output logic [cordic_pkg::WORD_WIDTH-1:0]   add_subt_dataA,
	output logic [cordic_pkg::WORD_WIDTH-1:0]   add_subt_dataB,
	output logic                                op_add_subt,
	output logic [cordic_pkg::WORD_WIDTH-1:0]   x_final,
	output logic [cordic_pkg::WORD_WIDTH-1:0]   y_final
);

	localparam int W = cordic_pkg::WORD_WIDTH;
	localparam int E = cordic_pkg::EXP_WIDTH;
	localparam int M = cordic_pkg::MANT_WIDTH;

	logic [W-1:0] z_init;                 // Angle captured at start.
	logic         first_iter;             // High until the first fetch is done.
	logic [W-1:0] x_cur, y_cur, z_cur;    // Values at the start of this iteration.
	logic [W-1:0] x_res, y_res, z_res;    // Adder results of this iteration.
	logic [W-1:0] x_shift, y_shift;       // X and Y scaled by 2^-iter.
	logic         z_sign;                 // Rotation direction.

	// Multiplying by 2^-n in float is just an exponent decrement.
	// A zero word must stay zero or its exponent would wrap to a huge value.
	function automatic logic [W-1:0] exp_shift(input logic [W-1:0] value,
		input logic [cordic_pkg::ITER_WIDTH-1:0] amount);
		logic [E-1:0] exp_field;
		exp_field = value[W-2:M];
		if (exp_field == '0)
			return value;
		return {value[W-1], exp_field - E'(amount), value[M-1:0]};
	endfunction

	//////////////////////////////////////////////////
	// Iteration registers.
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			first_iter <= 1'b0;
		else if (load_inputs)
			first_iter <= 1'b1; // Next fetch takes the initial values.
		else if (fetch_iter)
			first_iter <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (load_inputs)
			z_init <= data_in;
		if (fetch_iter)
		begin
			x_cur <= first_iter ? cordic_pkg::X_INIT : x_res; // X starts at 1/K.
			y_cur <= first_iter ? '0 : y_res;                 // Y starts at zero.
			z_cur <= first_iter ? z_init : z_res;
		end
		if (store_result)
		begin
			case (var_sel)
				cordic_pkg::var_x: x_res <= result_add_subt;
				cordic_pkg::var_y: y_res <= result_add_subt;
				default:           z_res <= result_add_subt;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Adder operand selection.
	//////////////////////////////////////////////////

	assign x_shift = exp_shift(x_cur, iter);
	assign y_shift = exp_shift(y_cur, iter);
	assign z_sign  = z_cur[W-1]; // Rotation mode, so the sign of Z steers.

	always_comb
	begin
		case (var_sel)
			cordic_pkg::var_x:
			begin
				add_subt_dataA = x_cur;
				add_subt_dataB = y_shift;
				op_add_subt    = ~z_sign; // X - Ys for a positive Z.
			end
			cordic_pkg::var_y:
			begin
				add_subt_dataA = y_cur;
				add_subt_dataB = x_shift;
				op_add_subt    = z_sign;  // Y + Xs for a positive Z.
			end
			default:
			begin
				add_subt_dataA = z_cur;
				add_subt_dataB = atan_value;
				op_add_subt    = ~z_sign; // Drive Z toward zero.
			end
		endcase
	end

	assign x_final = x_res;
	assign y_final = y_res;

endmodule

//--- verilog/cordic_pkg.sv
package cordic_pkg;

	//////////////////////////////////////////////////
	// Single precision word layout.
	//////////////////////////////////////////////////

	localparam int WORD_WIDTH = 32; // Sign, exponent and fraction together.
	localparam int EXP_WIDTH  = 8;  // Biased exponent field.
	localparam int MANT_WIDTH = 23; // Fraction field without the hidden bit.
	localparam int ITER_WIDTH = 5;  // Enough to index 32 rotations.

	// Reciprocal of the CORDIC gain, about 0.6072529.
	// X starts here so the final vector comes out unscaled.
	localparam logic [WORD_WIDTH-1:0] X_INIT = 32'h3f1b74ee;

	//////////////////////////////////////////////////
	// Sequencer states and operand selection.
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		idle,     // Waiting for a start strobe.
		load,     // Angle, operation and region are captured.
		fetch,    // X, Y and Z for the iteration are registered.
		request,  // One cycle pulse on beg_add_subt.
		wait_sum, // Stalled until the adder answers.
		store,    // Adder result is written back.
		next,     // Pick the next variable or iteration.
		finish,   // Output register loads.
		hold      // Result held until ack_cordic.
	} cordic_state_t;

	typedef enum logic [1:0] {
		var_x = 2'd0,
		var_y = 2'd1,
		var_z = 2'd2
	} cordic_var_t;

	// Quadrant the caller folded the angle from.
	typedef enum logic [1:0] {
		region_none = 2'd0,
		region_1    = 2'd1,
		region_2    = 2'd2,
		region_3    = 2'd3
	} region_t;

endpackage

//--- verilog/cordic_result_stage.sv
`timescale 1ns/100ps

module cordic_result_stage (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              load_inputs,
	input  logic                              out_load,
	input  logic                              operation,
	input  logic [1:0]                        shift_region_flag,
	input  logic [cordic_pkg::WORD_WIDTH-1:0] x_final,
	input  logic [cordic_pkg::WORD_WIDTH-1:0] y_final,
	output logic [cordic_pkg::WORD_WIDTH-1:0] data_output
);

	localparam int W = cordic_pkg::WORD_WIDTH;

	logic                op_sine;  // Captured operation, 1 for sine.
	cordic_pkg::region_t region;   // Captured quadrant flag.
	logic [W-1:0]        selected;
	logic                invert;

	always_ff @(posedge clk)
	begin
		if (load_inputs)
		begin
			op_sine <= operation;
			region  <= cordic_pkg::region_t'(shift_region_flag);
		end
	end

	// Cosine is negative in regions 1 and 2, sine in regions 2 and 3.
	always_comb
	begin
		selected = op_sine ? y_final : x_final;
		case (region)
			cordic_pkg::region_1: invert = ~op_sine;
			cordic_pkg::region_2: invert = 1'b1;
			cordic_pkg::region_3: invert = op_sine;
			default:              invert = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			data_output <= '0;
		else if (out_load)
			data_output <= {selected[W-1] ^ invert, selected[W-2:0]}; // Flip only the sign.
	end

endmodule
